//--- common/gmem_pkg.sv
`default_nettype none

package gmem_pkg;

   typedef logic [31:0] gmem_addr_t;
   typedef logic [31:0] gmem_data_t;
   typedef logic [1:0]  axi_id_t;
   typedef logic [15:0] beat_len_t;

   typedef enum logic [1:0] {
      job_copy = 2'd0,
      job_fill = 2'd1,
      job_sum  = 2'd2
   } job_kind_t;

   // one word on its way from reader to writer
   typedef struct packed {
      gmem_data_t data;
      logic       last;
   } gmem_beat_t;

   localparam int BURST_LEN = 8;

   localparam axi_id_t RD_ID = 2'd1;
   localparam axi_id_t WR_ID = 2'd2;

   localparam logic [1:0] AXI_OKAY   = 2'b00;
   localparam logic [1:0] AXI_SLVERR = 2'b10;

   // host register map, byte offsets
   localparam gmem_addr_t REG_SRC     = 32'h00;
   localparam gmem_addr_t REG_DST     = 32'h04;
   localparam gmem_addr_t REG_LEN     = 32'h08;
   localparam gmem_addr_t REG_PATTERN = 32'h0C;
   localparam gmem_addr_t REG_CTRL    = 32'h10;
   localparam gmem_addr_t REG_STATUS  = 32'h14;
   localparam gmem_addr_t REG_SUM     = 32'h18;

endpackage

`default_nettype wire

//--- dma/beat_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module beat_fifo import gmem_pkg::*; #(
   parameter int FIFO_DEPTH_W = 3
) (
   input  logic       clk,
   input  logic       nrst,
   input  logic       push,
   input  gmem_beat_t beat_in,
   output logic       full,
   input  logic       pop,
   output gmem_beat_t beat_out,
   output logic       empty
);

   localparam int DEPTH = 2 ** FIFO_DEPTH_W;

   gmem_beat_t              mem [DEPTH];
   logic [FIFO_DEPTH_W-1:0] wr_ptr;
   logic [FIFO_DEPTH_W-1:0] rd_ptr;
   logic [FIFO_DEPTH_W:0]   count;
   logic                    do_push;
   logic                    do_pop;

   assign full     = (count == (FIFO_DEPTH_W + 1)'(DEPTH));
   assign empty    = (count == '0);
   assign do_push  = push & ~full;
   assign do_pop   = pop & ~empty;
   // fall-through head
   assign beat_out = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= beat_in;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + (FIFO_DEPTH_W + 1)'(do_push) - (FIFO_DEPTH_W + 1)'(do_pop);
      end
   end

endmodule

`default_nettype wire

//--- dma/burst_reader.sv
`timescale 1ns/1ps
`default_nettype none

module burst_reader import gmem_pkg::*; (
   input  logic       clk,
   input  logic       nrst,
   input  logic       job_start,
   input  job_kind_t  kind,
   input  gmem_addr_t src,
   input  beat_len_t  len,
   output gmem_addr_t m_araddr,
   output logic [7:0] m_arlen,
   output logic       m_arvalid,
   input  logic       m_arready,
   output axi_id_t    m_arid,
   input  gmem_data_t m_rdata,
   input  logic       m_rlast,
   input  logic       m_rvalid,
   output logic       m_rready,
   input  axi_id_t    m_rid,
   output gmem_beat_t beat_out,
   output logic       push,
   input  logic       full,
   output gmem_data_t sum
);

   beat_len_t bursts_left;
   beat_len_t beats_left;
   logic      rd_beat;

   assign m_arlen  = 8'(BURST_LEN - 1);
   assign m_arid   = RD_ID;
   assign m_rready = ~full;
   assign rd_beat  = m_rvalid & m_rready & (m_rid == RD_ID);

   assign push          = rd_beat;
   assign beat_out.data = m_rdata;
   // rlast closes a burst, the counter closes the job
   assign beat_out.last = m_rlast && (beats_left == beat_len_t'(1));

   always_ff @(posedge clk) begin
      if (nrst) begin
         m_arvalid   <= 1'b0;
         bursts_left <= '0;
         beats_left  <= '0;
         sum         <= '0;
      end else if (job_start) begin
         sum      <= '0;
         m_araddr <= src;
         if (kind != job_fill) begin
            bursts_left <= len >> $clog2(BURST_LEN);
            beats_left  <= len;
         end
      end else begin
         if (m_arvalid && m_arready) begin
            m_arvalid   <= 1'b0;
            m_araddr    <= m_araddr + gmem_addr_t'(BURST_LEN * 4);
            bursts_left <= bursts_left - 1'b1;
         end else if (!m_arvalid && bursts_left != '0) begin
            m_arvalid <= 1'b1;
         end

         if (rd_beat) begin
            sum        <= sum + m_rdata;
            beats_left <= beats_left - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- dma/burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_writer import gmem_pkg::*; (
   input  logic       clk,
   input  logic       nrst,
   input  logic       job_start,
   input  job_kind_t  kind,
   input  gmem_addr_t dst,
   input  beat_len_t  len,
   input  gmem_data_t pattern,
   input  gmem_beat_t beat_in,
   input  logic       empty,
   output logic       pop,
   output gmem_addr_t m_awaddr,
   output logic [7:0] m_awlen,
   output logic       m_awvalid,
   input  logic       m_awready,
   output axi_id_t    m_awid,
   output gmem_data_t m_wdata,
   output logic [3:0] m_wstrb,
   output logic       m_wlast,
   output logic       m_wvalid,
   input  logic       m_wready,
   input  logic       m_bvalid,
   output logic       m_bready,
   input  axi_id_t    m_bid,
   output logic       job_done
);

   localparam int BEAT_W = $clog2(BURST_LEN);
   localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_LEN - 1);

   typedef enum logic [1:0] {wr_idle, wr_addr, wr_data, wr_resp} wr_state_t;

   wr_state_t         state;
   beat_len_t         bursts_left;
   logic [BEAT_W-1:0] beat_cnt;
   logic [2:0]        outstanding;
   logic              w_fire;
   logic              b_fire;

   assign m_awlen   = 8'(BURST_LEN - 1);
   assign m_awid    = WR_ID;
   assign m_awvalid = (state == wr_addr);
   assign m_wstrb   = '1;
   assign m_wlast   = (beat_cnt == LAST_BEAT);
   assign m_bready  = 1'b1;
   assign w_fire    = m_wvalid & m_wready;
   assign b_fire    = m_bvalid & m_bready & (m_bid == WR_ID);

   // beat source depends on the job kind
   always_comb begin
      m_wvalid = 1'b0;
      m_wdata  = beat_in.data;
      pop      = 1'b0;
      if (state == wr_data) begin
         case (kind)
            job_fill: begin
               m_wvalid = 1'b1;
               m_wdata  = pattern;
            end
            job_copy: begin
               m_wvalid = ~empty;
               pop      = ~empty & m_wready;
            end
            default: pop = ~empty;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         state       <= wr_idle;
         outstanding <= '0;
         job_done    <= 1'b0;
      end else begin
         job_done    <= 1'b0;
         outstanding <= outstanding + 3'(w_fire & m_wlast) - 3'(b_fire);
         case (state)
            wr_idle: begin
               if (job_start) begin
                  m_awaddr    <= dst;
                  bursts_left <= len >> BEAT_W;
                  beat_cnt    <= '0;
                  state       <= (kind == job_sum) ? wr_data : wr_addr;
               end
            end
            wr_addr: begin
               if (m_awready) begin
                  state <= wr_data;
               end
            end
            wr_data: begin
               if (kind == job_sum) begin
                  // drain only
                  if (!empty && beat_in.last) begin
                     job_done <= 1'b1;
                     state    <= wr_idle;
                  end
               end else if (w_fire) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (m_wlast) begin
                     m_awaddr    <= m_awaddr + gmem_addr_t'(BURST_LEN * 4);
                     bursts_left <= bursts_left - 1'b1;
                     state <= (bursts_left == beat_len_t'(1)) ? wr_resp : wr_addr;
                  end
               end
            end
            default: begin
               if (b_fire && outstanding == 3'd1) begin
                  job_done <= 1'b1;
                  state    <= wr_idle;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- global_mem/global_mem.sv
`timescale 1ns/1ps
`default_nettype none

module global_mem import gmem_pkg::*; #(
   parameter int         MEM_ADDR_W  = 10,
   parameter gmem_addr_t ADDR_OFFSET = 32'h1000_0000,
   parameter int         FILL_MODULO = 49
) (
   input  logic       clk,
   input  logic       nrst,
   input  gmem_addr_t m_araddr,
   input  logic [7:0] m_arlen,
   input  logic       m_arvalid,
   output logic       m_arready,
   input  axi_id_t    m_arid,
   output gmem_data_t m_rdata,
   output logic       m_rlast,
   output logic       m_rvalid,
   input  logic       m_rready,
   output axi_id_t    m_rid,
   input  gmem_addr_t m_awaddr,
   input  logic [7:0] m_awlen,
   input  logic       m_awvalid,
   output logic       m_awready,
   input  axi_id_t    m_awid,
   input  gmem_data_t m_wdata,
   input  logic [3:0] m_wstrb,
   input  logic       m_wlast,
   input  logic       m_wvalid,
   output logic       m_wready,
   output logic       m_bvalid,
   input  logic       m_bready,
   output axi_id_t    m_bid
);

   localparam int AQ_DEPTH_W = 2;
   localparam int AQ_DEPTH   = 2 ** AQ_DEPTH_W;

   typedef enum logic {rd_idle, rd_send} rd_state_t;

   gmem_data_t mem [2 ** MEM_ADDR_W];

   rd_state_t             rd_state;
   logic [MEM_ADDR_W-1:0] rd_idx;
   logic [7:0]            rd_left;
   gmem_addr_t            ar_off;
   gmem_addr_t            aw_off;

   // aw queue, word index, id and length per entry
   logic [MEM_ADDR_W-1:0] aq_idx [AQ_DEPTH];
   axi_id_t               aq_id  [AQ_DEPTH];
   logic [7:0]            aq_len [AQ_DEPTH];
   logic [AQ_DEPTH_W-1:0] aq_wr;
   logic [AQ_DEPTH_W-1:0] aq_rd;
   logic [AQ_DEPTH_W:0]   aq_count;
   logic [7:0]            w_cnt;
   logic [MEM_ADDR_W-1:0] w_idx;
   logic                  aw_fire;
   logic                  w_fire;
   logic                  w_end;

   assign ar_off    = m_araddr - ADDR_OFFSET;
   assign aw_off    = m_awaddr - ADDR_OFFSET;
   assign m_awready = (aq_count != (AQ_DEPTH_W + 1)'(AQ_DEPTH));
   assign aw_fire   = m_awvalid & m_awready;
   assign w_fire    = m_wvalid & m_wready;
   // a burst also ends at its declared length
   assign w_end     = w_fire & (m_wlast | (w_cnt == aq_len[aq_rd]));
   assign w_idx     = aq_idx[aq_rd] + MEM_ADDR_W'(w_cnt);

   initial begin
      for (int i = 0; i < 2 ** MEM_ADDR_W; i++) begin
         mem[i] = gmem_data_t'(i % FILL_MODULO);
      end
   end

   always_ff @(posedge clk) begin
      if (w_fire) begin
         for (int b = 0; b < 4; b++) begin
            if (m_wstrb[b]) begin
               mem[w_idx][b*8 +: 8] <= m_wdata[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         rd_state  <= rd_idle;
         m_arready <= 1'b0;
         m_rvalid  <= 1'b0;
         m_rlast   <= 1'b0;
      end else begin
         m_arready <= 1'b0;
         case (rd_state)
            rd_idle: begin
               if (m_arready) begin
                  m_rdata  <= mem[ar_off[MEM_ADDR_W+1:2]];
                  m_rid    <= m_arid;
                  m_rvalid <= 1'b1;
                  m_rlast  <= (m_arlen == 8'd0);
                  rd_idx   <= ar_off[MEM_ADDR_W+1:2] + 1'b1;
                  rd_left  <= m_arlen;
                  rd_state <= rd_send;
               end else if (m_arvalid) begin
                  m_arready <= 1'b1;
               end
            end
            default: begin
               if (m_rready) begin
                  if (m_rlast) begin
                     m_rvalid <= 1'b0;
                     m_rlast  <= 1'b0;
                     rd_state <= rd_idle;
                  end else begin
                     m_rdata <= mem[rd_idx];
                     rd_idx  <= rd_idx + 1'b1;
                     rd_left <= rd_left - 1'b1;
                     m_rlast <= (rd_left == 8'd1);
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         aq_wr    <= '0;
         aq_rd    <= '0;
         aq_count <= '0;
         w_cnt    <= '0;
         m_wready <= 1'b0;
         m_bvalid <= 1'b0;
      end else begin
         m_wready <= 1'b1;
         if (aw_fire) begin
            aq_idx[aq_wr] <= aw_off[MEM_ADDR_W+1:2];
            aq_id[aq_wr]  <= m_awid;
            aq_len[aq_wr] <= m_awlen;
            aq_wr         <= aq_wr + 1'b1;
         end
         if (w_end) begin
            w_cnt <= '0;
            aq_rd <= aq_rd + 1'b1;
         end else if (w_fire) begin
            w_cnt <= w_cnt + 1'b1;
         end
         aq_count <= aq_count + (AQ_DEPTH_W + 1)'(aw_fire) - (AQ_DEPTH_W + 1)'(w_end);

         if (w_end) begin
            m_bvalid <= 1'b1;
            m_bid    <= aq_id[aq_rd];
         end else if (m_bready) begin
            m_bvalid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- gmem_engine.f
+incdir+verification
common/gmem_pkg.sv
verilog/job_regs.sv
dma/burst_reader.sv
dma/beat_fifo.sv
dma/burst_writer.sv
global_mem/global_mem.sv
verilog/gmem_engine_top.sv
verification/gmem_engine_assertions.sv
verification/gmem_engine_tb.sv

//--- verification/gmem_engine_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module gmem_engine_assertions import gmem_pkg::*; (
   input logic       clk,
   input logic       nrst,
   input gmem_addr_t m_araddr,
   input logic       m_arvalid,
   input logic       m_arready,
   input gmem_addr_t m_awaddr,
   input logic       m_awvalid,
   input logic       m_awready,
   input logic       m_rvalid,
   input logic       m_rready,
   input logic       m_rlast,
   input logic       m_wvalid,
   input logic       m_wready,
   input logic       m_wlast,
   input logic       m_bvalid,
   input logic       busy,
   input logic       done
);

   int         fail_count = 0;
   logic [2:0] r_beat;

   // position of the next R beat inside its burst
   always_ff @(posedge clk) begin
      if (nrst) begin
         r_beat <= '0;
      end else if (m_rvalid && m_rready) begin
         r_beat <= r_beat + 1'b1;
      end
   end

   ar_stable: assert property (@(posedge clk) disable iff (nrst)
      m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
   else begin
      fail_count++;
      $error("ARVALID or ARADDR changed before ARREADY");
   end

   aw_stable: assert property (@(posedge clk) disable iff (nrst)
      m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr))
   else begin
      fail_count++;
      $error("AWVALID or AWADDR changed before AWREADY");
   end

   rlast_every_8th: assert property (@(posedge clk) disable iff (nrst)
      m_rvalid && m_rready |-> (m_rlast == (r_beat == 3'd7)))
   else begin
      fail_count++;
      $error("RLAST not on the 8th beat of a burst");
   end

   bvalid_after_wlast: assert property (@(posedge clk) disable iff (nrst)
      $rose(m_bvalid) |-> $past(m_wvalid && m_wready && m_wlast))
   else begin
      fail_count++;
      $error("BVALID rose without a WLAST handshake");
   end

   // a finished job leaves the memory port quiet
   busy_done_exclusive: assert property (@(posedge clk) disable iff (nrst)
      done |-> !busy && !m_arvalid && !m_awvalid && !m_wvalid)
   else begin
      fail_count++;
      $error("busy or memory traffic while done is high");
   end

endmodule

`default_nettype wire

//--- verification/gmem_engine_checks.svh
`ifndef GMEM_ENGINE_CHECKS_SVH
`define GMEM_ENGINE_CHECKS_SVH

task automatic roundtrip_reg(input string name, input gmem_addr_t addr, input gmem_data_t value);
   logic [1:0] resp;
   gmem_data_t data;
   write_reg(addr, value, resp);
   check_value({"bresp ", name}, 32'(resp), 32'(AXI_OKAY));
   read_reg(addr, data, resp);
   check_value({"rresp ", name}, 32'(resp), 32'(AXI_OKAY));
   check_value({"rdata ", name}, data, value);
endtask

task automatic start_job(input job_kind_t job, input int src_idx, input int dst_idx,
                         input int beats);
   logic [1:0] resp;
   write_reg(REG_SRC, word_addr(src_idx), resp);
   write_reg(REG_DST, word_addr(dst_idx), resp);
   write_reg(REG_LEN, gmem_data_t'(beats), resp);
   write_reg(REG_CTRL, START_BIT | gmem_data_t'(job), resp);
endtask

// poll status until done
task automatic wait_done(output gmem_data_t status);
   logic [1:0] resp;
   status = '0;
   while (!status[1]) begin
      read_reg(REG_STATUS, status, resp);
   end
endtask

task automatic expect_sum(input string name, input gmem_data_t exp);
   logic [1:0] resp;
   gmem_data_t data;
   read_reg(REG_SUM, data, resp);
   check_value(name, data, exp);
endtask

task automatic check_registers;
   logic [1:0] resp;
   gmem_data_t data;
   roundtrip_reg("src", REG_SRC, word_addr(12));
   roundtrip_reg("dst", REG_DST, word_addr(99));
   roundtrip_reg("len", REG_LEN, 32'd40);
   roundtrip_reg("pattern", REG_PATTERN, 32'hcafe_0123);
   write_reg(UNMAPPED, 32'h1, resp);
   check_value("bresp unmapped", 32'(resp), 32'(AXI_SLVERR));
   read_reg(UNMAPPED, data, resp);
   check_value("rresp unmapped", 32'(resp), 32'(AXI_SLVERR));
   check_value("rdata unmapped", data, 32'h0);
endtask

task automatic check_sum_job;
   gmem_data_t status;
   start_job(job_sum, 10, 0, 64);
   wait_done(status);
   check_value("status after sum", status, 32'h2);
   expect_sum("sum at index 10", expected_sum(10, 64));
endtask

task automatic check_copy_job;
   gmem_data_t status;
   logic [1:0] resp;
   start_job(job_copy, 10, 200, 64);
   read_reg(REG_STATUS, status, resp);
   check_value("status.busy during copy", 32'(status[0]), 32'd1);
   // this start lands while the copy is running
   write_reg(REG_CTRL, START_BIT | gmem_data_t'(job_fill), resp);
   wait_done(status);
   expect_sum("sum after copy", expected_sum(10, 64));
   start_job(job_sum, 200, 0, 64);
   wait_done(status);
   expect_sum("sum at index 200", expected_sum(10, 64));
endtask

task automatic check_fill_job;
   gmem_data_t status;
   logic [1:0] resp;
   write_reg(REG_PATTERN, 32'h11, resp);
   start_job(job_fill, 0, 300, 32);
   wait_done(status);
   expect_sum("sum after fill", 32'h0);
   start_job(job_sum, 300, 0, 32);
   wait_done(status);
   expect_sum("sum at index 300", gmem_data_t'(32 * 32'h11));
endtask

`endif

//--- verification/gmem_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gmem_engine_tb import gmem_pkg::*; ();

   localparam int          CLK_HALF       = 20;
   localparam int          DRIVE_DELAY    = 2;
   localparam int          RESET_CYCLES   = 8;
   // 4 jobs of about 200 cycles plus generous room for register traffic
   localparam int          TIMEOUT_CYCLES = 20000;
   localparam gmem_addr_t  MEM_BASE       = 32'h1000_0000;
   localparam int          FILL_MODULO    = 49;
   localparam logic [31:0] SEED           = 32'habbc;
   localparam gmem_addr_t  UNMAPPED       = 32'h40;
   localparam gmem_data_t  START_BIT      = 32'h10;

   logic       clk;
   logic       nrst;
   gmem_addr_t s_awaddr;
   logic       s_awvalid;
   logic       s_awready;
   gmem_data_t s_wdata;
   logic       s_wvalid;
   logic       s_wready;
   logic [1:0] s_bresp;
   logic       s_bvalid;
   logic       s_bready;
   gmem_addr_t s_araddr;
   logic       s_arvalid;
   logic       s_arready;
   gmem_data_t s_rdata;
   logic [1:0] s_rresp;
   logic       s_rvalid;
   logic       s_rready;

   logic [31:0] rand_state;
   int          errors;
   int          checks;
   int          assert_fails;
   int          cycles;

   gmem_engine_top gmem_engine_top_inst (.*);

   bind gmem_engine_top gmem_engine_assertions gmem_engine_assertions_inst (
      .*,
      .busy (job_regs_inst.busy),
      .done (job_regs_inst.done)
   );

   always #CLK_HALF clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic random_ready();
      rand_state = xorshift32(rand_state);
      return rand_state[0];
   endfunction

   // init rule of global memory
   function automatic gmem_data_t expected_sum(input int first, input int count);
      gmem_data_t acc;
      acc = '0;
      for (int i = first; i < first + count; i++) begin
         acc = acc + gmem_data_t'(i % FILL_MODULO);
      end
      return acc;
   endfunction

   function automatic gmem_addr_t word_addr(input int idx);
      return MEM_BASE + gmem_addr_t'(idx * 4);
   endfunction

   task automatic tick;
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAILED at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      end
   endtask

   task automatic write_reg(input gmem_addr_t addr, input gmem_data_t data,
                            output logic [1:0] resp);
      logic fired;
      s_awaddr  = addr;
      s_wdata   = data;
      s_awvalid = 1'b1;
      s_wvalid  = 1'b1;
      @(negedge clk);
      while (!(s_awready && s_wready)) @(negedge clk);
      tick();
      s_awvalid = 1'b0;
      s_wvalid  = 1'b0;
      fired     = 1'b0;
      resp      = '0;
      while (!fired) begin
         s_bready = random_ready();
         @(negedge clk);
         fired = s_bvalid && s_bready;
         resp  = s_bresp;
         tick();
      end
      s_bready = 1'b0;
   endtask

   task automatic read_reg(input gmem_addr_t addr, output gmem_data_t data,
                           output logic [1:0] resp);
      logic fired;
      s_araddr  = addr;
      s_arvalid = 1'b1;
      @(negedge clk);
      while (!s_arready) @(negedge clk);
      tick();
      s_arvalid = 1'b0;
      fired     = 1'b0;
      data      = '0;
      resp      = '0;
      while (!fired) begin
         s_rready = random_ready();
         @(negedge clk);
         fired = s_rvalid && s_rready;
         data  = s_rdata;
         resp  = s_rresp;
         tick();
      end
      s_rready = 1'b0;
   endtask

`include "gmem_engine_checks.svh"

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
   end

   initial begin
      clk        = 1'b0;
      nrst       = 1'b1;
      s_awaddr   = '0;
      s_awvalid  = 1'b0;
      s_wdata    = '0;
      s_wvalid   = 1'b0;
      s_bready   = 1'b0;
      s_araddr   = '0;
      s_arvalid  = 1'b0;
      s_rready   = 1'b0;
      rand_state = SEED;
      errors     = 0;
      checks     = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      nrst = 1'b0;
      tick();

      check_registers();
      check_sum_job();
      check_copy_job();
      check_fill_job();
      tick();

      assert_fails = gmem_engine_top_inst.gmem_engine_assertions_inst.fail_count;
      $display("Summary: %0d value checks, %0d value errors, %0d assertion failures",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/gmem_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

module gmem_engine_top import gmem_pkg::*; #(
   parameter int         MEM_ADDR_W   = 10,
   parameter gmem_addr_t ADDR_OFFSET  = 32'h1000_0000,
   parameter int         FILL_MODULO  = 49,
   parameter int         FIFO_DEPTH_W = 3
) (
   input  logic       clk,
   input  logic       nrst,
   input  gmem_addr_t s_awaddr,
   input  logic       s_awvalid,
   output logic       s_awready,
   input  gmem_data_t s_wdata,
   input  logic       s_wvalid,
   output logic       s_wready,
   output logic [1:0] s_bresp,
   output logic       s_bvalid,
   input  logic       s_bready,
   input  gmem_addr_t s_araddr,
   input  logic       s_arvalid,
   output logic       s_arready,
   output gmem_data_t s_rdata,
   output logic [1:0] s_rresp,
   output logic       s_rvalid,
   input  logic       s_rready
);

   gmem_addr_t src;
   gmem_addr_t dst;
   beat_len_t  len;
   gmem_data_t pattern;
   job_kind_t  kind;
   logic       job_start;
   logic       job_done;
   gmem_data_t sum;

   // reader to fifo to writer
   gmem_beat_t rd_beat;
   gmem_beat_t wr_beat;
   logic       push;
   logic       full;
   logic       pop;
   logic       empty;

   // memory port
   gmem_addr_t m_araddr;
   logic [7:0] m_arlen;
   logic       m_arvalid;
   logic       m_arready;
   axi_id_t    m_arid;
   gmem_data_t m_rdata;
   logic       m_rlast;
   logic       m_rvalid;
   logic       m_rready;
   axi_id_t    m_rid;
   gmem_addr_t m_awaddr;
   logic [7:0] m_awlen;
   logic       m_awvalid;
   logic       m_awready;
   axi_id_t    m_awid;
   gmem_data_t m_wdata;
   logic [3:0] m_wstrb;
   logic       m_wlast;
   logic       m_wvalid;
   logic       m_wready;
   logic       m_bvalid;
   logic       m_bready;
   axi_id_t    m_bid;

   job_regs job_regs_inst (.*);

   burst_reader burst_reader_inst (
      .*,
      .beat_out (rd_beat)
   );

   beat_fifo #(
      .FIFO_DEPTH_W (FIFO_DEPTH_W)
   ) beat_fifo_inst (
      .*,
      .beat_in  (rd_beat),
      .beat_out (wr_beat)
   );

   burst_writer burst_writer_inst (
      .*,
      .beat_in (wr_beat)
   );

   global_mem #(
      .MEM_ADDR_W  (MEM_ADDR_W),
      .ADDR_OFFSET (ADDR_OFFSET),
      .FILL_MODULO (FILL_MODULO)
   ) global_mem_inst (.*);

endmodule

`default_nettype wire

//--- verilog/job_regs.sv
`timescale 1ns/1ps
`default_nettype none

module job_regs import gmem_pkg::*; (
   input  logic       clk,
   input  logic       nrst,
   input  gmem_addr_t s_awaddr,
   input  logic       s_awvalid,
   output logic       s_awready,
   input  gmem_data_t s_wdata,
   input  logic       s_wvalid,
   output logic       s_wready,
   output logic [1:0] s_bresp,
   output logic       s_bvalid,
   input  logic       s_bready,
   input  gmem_addr_t s_araddr,
   input  logic       s_arvalid,
   output logic       s_arready,
   output gmem_data_t s_rdata,
   output logic [1:0] s_rresp,
   output logic       s_rvalid,
   input  logic       s_rready,
   output gmem_addr_t src,
   output gmem_addr_t dst,
   output beat_len_t  len,
   output gmem_data_t pattern,
   output job_kind_t  kind,
   output logic       job_start,
   input  logic       job_done,
   input  gmem_data_t sum
);

   logic       busy;
   logic       done;
   logic       wr_fire;
   logic       rd_fire;
   gmem_data_t rd_word;
   logic       rd_ok;

   // write needs both channels at once and no response pending
   assign wr_fire   = s_awvalid & s_wvalid & ~s_bvalid;
   assign s_awready = wr_fire;
   assign s_wready  = wr_fire;
   assign rd_fire   = s_arvalid & ~s_rvalid;
   assign s_arready = rd_fire;

   always_comb begin
      rd_word = '0;
      rd_ok   = 1'b1;
      case (s_araddr)
         REG_SRC:     rd_word = src;
         REG_DST:     rd_word = dst;
         REG_LEN:     rd_word = gmem_data_t'(len);
         REG_PATTERN: rd_word = pattern;
         REG_CTRL:    rd_word = gmem_data_t'(kind);
         REG_STATUS:  rd_word = {30'b0, done, busy};
         REG_SUM:     rd_word = sum;
         default:     rd_ok = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         s_bvalid  <= 1'b0;
         s_rvalid  <= 1'b0;
         job_start <= 1'b0;
         busy      <= 1'b0;
         done      <= 1'b0;
         kind      <= job_copy;
      end else begin
         job_start <= 1'b0;
         if (wr_fire) begin
            s_bvalid <= 1'b1;
            s_bresp  <= AXI_OKAY;
            case (s_awaddr)
               REG_SRC:     src <= s_wdata;
               REG_DST:     dst <= s_wdata;
               REG_LEN:     len <= s_wdata[15:0];
               REG_PATTERN: pattern <= s_wdata;
               REG_CTRL: begin
                  // the running job keeps its kind
                  if (!busy) begin
                     kind <= job_kind_t'(s_wdata[1:0]);
                     if (s_wdata[4]) begin
                        job_start <= 1'b1;
                        busy      <= 1'b1;
                        done      <= 1'b0;
                     end
                  end
               end
               REG_STATUS, REG_SUM: ;
               default: s_bresp <= AXI_SLVERR;
            endcase
         end else if (s_bready) begin
            s_bvalid <= 1'b0;
         end

         if (rd_fire) begin
            s_rvalid <= 1'b1;
            s_rdata  <= rd_word;
            s_rresp  <= rd_ok ? AXI_OKAY : AXI_SLVERR;
         end else if (s_rready) begin
            s_rvalid <= 1'b0;
         end

         if (job_done) begin
            busy <= 1'b0;
            done <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire
